// ==== verilog/vrf_cfg_pkg.sv ====
package vrf_cfg_pkg;

  // Element width, stored as the shift that turns elements into bytes
  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2
  } vsew_e;

  // Data memory word
  localparam int unsigned WORD_BYTES = 4;

  // All byte lanes enabled
  localparam logic [WORD_BYTES-1:0] BE_FULL = '1;

  // Number of memory words in one vector register
  function automatic int unsigned max_words(int unsigned vlen);
    return vlen / (WORD_BYTES * 8);
  endfunction

  // Counter width able to hold 0 .. max_words
  function automatic int unsigned words_w(int unsigned vlen);
    return $clog2(max_words(vlen) + 1);
  endfunction

endpackage

// ==== verilog/vrf_seq_pkg.sv ====
package vrf_seq_pkg;

  // Sequencer states
  // READ1/READ2 fetch the source operands, WRITE stores the result word
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    READ1 = 3'd1,
    READ2 = 3'd2,
    WRITE = 3'd3,
    DONE  = 3'd4
  } vrf_state_e;

  // Bit positions in sel_operation_i
  // Bit 2 was the RS3 read and is ignored here
  localparam int unsigned SEL_RS1 = 0;
  localparam int unsigned SEL_RS2 = 1;
  localparam int unsigned SEL_RD  = 3;

endpackage

// ==== verilog/vrf_length_calc.sv ====
`timescale 1ns/1ns

module vrf_length_calc import vrf_cfg_pkg::*; #(
  parameter int unsigned VLEN = 128
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  logic [31:0]               vl_i,
  input  vsew_e                     sew_i,
  output logic [words_w(VLEN)-1:0]  num_words_o,
  output logic [3:0]                tail_be_o
);

  localparam int unsigned CNT_W = words_w(VLEN);
  localparam int unsigned OFS_W = $clog2(WORD_BYTES);

  logic [31:0]      vl_q;
  vsew_e            sew_q;
  logic [33:0]      num_bytes;
  logic [33:0]      words_full;
  logic [OFS_W-1:0] tail_bytes;

  // Length is sampled once per instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vl_q  <= '0;
      sew_q <= SEW_8;
    end else if (start_i) begin
      vl_q  <= vl_i;
      sew_q <= sew_i;
    end
  end

  assign num_bytes  = {2'b00, vl_q} << sew_q;
  assign tail_bytes = num_bytes[OFS_W-1:0];

  // Round up to whole words
  assign words_full  = (num_bytes + 34'(WORD_BYTES - 1)) >> OFS_W;
  assign num_words_o = words_full[CNT_W-1:0];

  // Partial last word keeps only the low lanes
  assign tail_be_o = (tail_bytes == '0) ? BE_FULL : ~(BE_FULL << tail_bytes);

  // A run never covers more than one vector register
  a_words_fit : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    start_i |=> (words_full <= 34'(max_words(VLEN)))
  ) else $error("vector length exceeds register capacity");

endmodule

// ==== verilog/vrf_access_fsm.sv ====
`timescale 1ns/1ns

module vrf_access_fsm import vrf_cfg_pkg::*; import vrf_seq_pkg::*; #(
  parameter int unsigned VLEN = 128
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic [3:0]                sel_operation_i,
  input  logic [words_w(VLEN)-1:0]  num_words_i,
  input  logic [3:0]                tail_be_i,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  output logic                      start_o,
  output logic                      ack_o,
  output logic                      data_req_o,
  output logic                      data_we_o,
  output logic [3:0]                data_be_o,
  output logic                      rs1_en_o,
  output logic                      rs2_en_o,
  output logic                      agu_load_o,
  output logic                      agu_get_rs1_o,
  output logic                      agu_get_rs2_o,
  output logic                      agu_get_rd_o,
  output logic                      agu_incr_o
);

  localparam int unsigned CNT_W = words_w(VLEN);

  vrf_state_e       state_q, state_d;
  vrf_state_e       first_op, next_op;
  logic [CNT_W-1:0] words_done_q, words_done_d;
  logic             pend_rs1_q, pend_rs2_q;
  logic             pending;
  logic             no_words;
  logic             last_word;
  logic             word_end;
  logic             rd_req, wr_req;
  logic             granted;

  //////////////////////////////////////////////////////////////////////
  // Request generation
  //////////////////////////////////////////////////////////////////////

  assign pending   = pend_rs1_q | pend_rs2_q;
  assign no_words  = (num_words_i == '0);
  assign last_word = (words_done_q == num_words_i - 1'b1);

  assign rd_req = ((state_q == READ1) || (state_q == READ2)) && !no_words;
  // Result word is only valid once both operands have landed
  assign wr_req = (state_q == WRITE) && !no_words && !pending;

  assign data_req_o = rd_req | wr_req;
  assign data_we_o  = wr_req;
  assign granted    = data_req_o & data_gnt_i;
  assign data_be_o  = ((state_q == WRITE) && last_word) ? tail_be_i : BE_FULL;

  assign start_o       = (state_q == IDLE) && req_i;
  assign agu_load_o    = start_o;
  assign agu_get_rs1_o = rd_req && (state_q == READ1);
  assign agu_get_rs2_o = rd_req && (state_q == READ2);
  assign agu_get_rd_o  = wr_req;
  assign agu_incr_o    = granted;

  // Read data belongs to the single outstanding read
  assign rs1_en_o = data_rvalid_i & pend_rs1_q;
  assign rs2_en_o = data_rvalid_i & pend_rs2_q;

  assign ack_o = (state_q == DONE) && !pending;

  //////////////////////////////////////////////////////////////////////
  // Operation order within a word
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (sel_operation_i[SEL_RS1]) begin
      first_op = READ1;
    end else if (sel_operation_i[SEL_RS2]) begin
      first_op = READ2;
    end else if (sel_operation_i[SEL_RD]) begin
      first_op = WRITE;
    end else begin
      first_op = DONE;
    end
  end

  always_comb begin
    next_op  = WRITE;
    word_end = 1'b1;
    case (state_q)
      READ1: begin
        next_op  = sel_operation_i[SEL_RS2] ? READ2 : WRITE;
        word_end = !sel_operation_i[SEL_RS2] && !sel_operation_i[SEL_RD];
      end
      READ2: begin
        word_end = !sel_operation_i[SEL_RD];
      end
      default: begin
        word_end = 1'b1;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and word counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    words_done_d = words_done_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d      = first_op;
          words_done_d = '0;
        end
      end
      READ1, READ2, WRITE: begin
        if (no_words) begin
          state_d = DONE;
        end else if (granted) begin
          if (!word_end) begin
            state_d = next_op;
          end else if (last_word) begin
            state_d = DONE;
          end else begin
            // Next word starts over at the first selected operation
            words_done_d = words_done_q + 1'b1;
            state_d      = first_op;
          end
        end
      end
      DONE: begin
        if (!pending && !req_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      words_done_q <= '0;
      pend_rs1_q   <= 1'b0;
      pend_rs2_q   <= 1'b0;
    end else begin
      state_q      <= state_d;
      words_done_q <= words_done_d;
      if (data_rvalid_i) begin
        pend_rs1_q <= 1'b0;
        pend_rs2_q <= 1'b0;
      end
      // A new grant may coincide with the previous rvalid
      if (granted && (state_q == READ1)) begin
        pend_rs1_q <= 1'b1;
      end
      if (granted && (state_q == READ2)) begin
        pend_rs2_q <= 1'b1;
      end
    end
  end

  a_req_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (data_req_o && !data_gnt_i) |=> data_req_o
  ) else $error("data_req_o dropped before grant");

  a_ack_in_handshake : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> (req_i || $past(req_i))
  ) else $error("ack_o high outside the req/ack handshake");

endmodule

// ==== verilog/vrf_operand_regs.sv ====
`timescale 1ns/1ns

module vrf_operand_regs (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rs1_en_i,
  input  logic        rs2_en_i,
  input  logic [31:0] data_rdata_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o
);

  logic [31:0] rs1_q;
  logic [31:0] rs2_q;

  // Both operands share the memory read bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_q <= '0;
    end else if (rs1_en_i) begin
      rs1_q <= data_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rs2_q <= '0;
    end else if (rs2_en_i) begin
      rs2_q <= data_rdata_i;
    end
  end

  // Operands to the execution unit
  assign rdata_a_o = rs1_q;
  assign rdata_b_o = rs2_q;

  // One rvalid serves one read only
  a_single_capture : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(rs1_en_i && rs2_en_i)
  ) else $error("rvalid claimed by both operands");

endmodule

// ==== verilog/vrf_interface.sv ====
`timescale 1ns/1ns

module vrf_interface import vrf_cfg_pkg::*; #(
  parameter int unsigned VLEN = 128
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Instruction handshake
  input  logic        req_i,
  input  logic [3:0]  sel_operation_i,
  input  logic [31:0] vl_i,
  input  vsew_e       sew_i,
  output logic        ack_o,

  // Execution unit
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o,

  // Data memory
  output logic        data_req_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  output logic        data_we_o,
  output logic [3:0]  data_be_o,
  output logic [31:0] data_wdata_o,
  input  logic [31:0] data_rdata_i,

  // Address generator
  output logic        agu_load_o,
  output logic        agu_get_rs1_o,
  output logic        agu_get_rs2_o,
  output logic        agu_get_rd_o,
  output logic        agu_incr_o
);

  logic                     start;
  logic [words_w(VLEN)-1:0] num_words;
  logic [3:0]               tail_be;
  logic                     rs1_en;
  logic                     rs2_en;

  vrf_length_calc #(
    .VLEN        (VLEN)
  ) u_length_calc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start),
    .vl_i        (vl_i),
    .sew_i       (sew_i),
    .num_words_o (num_words),
    .tail_be_o   (tail_be)
  );

  vrf_access_fsm #(
    .VLEN            (VLEN)
  ) u_access_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .sel_operation_i (sel_operation_i),
    .num_words_i     (num_words),
    .tail_be_i       (tail_be),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .start_o         (start),
    .ack_o           (ack_o),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .data_be_o       (data_be_o),
    .rs1_en_o        (rs1_en),
    .rs2_en_o        (rs2_en),
    .agu_load_o      (agu_load_o),
    .agu_get_rs1_o   (agu_get_rs1_o),
    .agu_get_rs2_o   (agu_get_rs2_o),
    .agu_get_rd_o    (agu_get_rd_o),
    .agu_incr_o      (agu_incr_o)
  );

  vrf_operand_regs u_operand_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rs1_en_i     (rs1_en),
    .rs2_en_i     (rs2_en),
    .data_rdata_i (data_rdata_i),
    .rdata_a_o    (rdata_a_o),
    .rdata_b_o    (rdata_b_o)
  );

  // Result word goes out unbuffered
  assign data_wdata_o = wdata_i;

endmodule

// ==== bench/tb_vrf_interface.sv ====
`timescale 1ns/1ns

module tb_vrf_interface
  import vrf_cfg_pkg::*;
  import vrf_seq_pkg::*;
();

  localparam int NUM_TESTS  = 9;
  localparam int NUM_PASSES = 2;
  localparam int OP_RS1     = 0;
  localparam int OP_RS2     = 1;
  localparam int OP_RD      = 2;

  // Operation select, vector length and element width per test
  localparam logic [3:0] TBL_SEL [NUM_TESTS] = '{
    4'b1011, 4'b1011, 4'b1001, 4'b1010, 4'b0011, 4'b1000, 4'b0100, 4'b0001, 4'b1111
  };
  localparam int unsigned TBL_VL [NUM_TESTS] = '{4, 5, 7, 3, 3, 9, 4, 1, 2};
  localparam vsew_e TBL_SEW [NUM_TESTS] = '{
    SEW_32, SEW_16, SEW_8, SEW_32, SEW_16, SEW_8, SEW_8, SEW_8, SEW_16
  };

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        req_i;
  logic [3:0]  sel_operation_i;
  logic [31:0] vl_i;
  vsew_e       sew_i;
  logic        ack_o;
  logic [31:0] wdata_i = '0;
  logic [31:0] rdata_a_o;
  logic [31:0] rdata_b_o;
  logic        data_req_o;
  logic        data_gnt_i = 1'b0;
  logic        data_rvalid_i = 1'b0;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_wdata_o;
  logic [31:0] data_rdata_i = '0;
  logic        agu_load_o;
  logic        agu_get_rs1_o;
  logic        agu_get_rs2_o;
  logic        agu_get_rd_o;
  logic        agu_incr_o;

  // Memory model state
  logic [31:0] lfsr_q = 32'd83523;
  logic        send_rvalid = 1'b0;
  logic        stall_en;

  // Scoreboard
  int          err_cnt;
  int          tests_ok;
  int          tests_bad;
  logic        active;
  int          exp_ops [3];
  int          nops;
  int          exp_words;
  logic [3:0]  exp_tail;
  int          exp_grants;
  int          grant_cnt;
  int          incr_cnt;
  int          load_cnt;
  int          reads_out;
  int          reads_back;
  logic        read_is_rs1;
  logic [31:0] last_rs1;
  logic [31:0] last_rs2;

  vrf_interface uut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .sel_operation_i (sel_operation_i),
    .vl_i            (vl_i),
    .sew_i           (sew_i),
    .ack_o           (ack_o),
    .wdata_i         (wdata_i),
    .rdata_a_o       (rdata_a_o),
    .rdata_b_o       (rdata_b_o),
    .data_req_o      (data_req_o),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_we_o       (data_we_o),
    .data_be_o       (data_be_o),
    .data_wdata_o    (data_wdata_o),
    .data_rdata_i    (data_rdata_i),
    .agu_load_o      (agu_load_o),
    .agu_get_rs1_o   (agu_get_rs1_o),
    .agu_get_rs2_o   (agu_get_rs2_o),
    .agu_get_rd_o    (agu_get_rd_o),
    .agu_incr_o      (agu_incr_o)
  );

  always #10 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Expected word count and tail lanes from the vector length
  function automatic int word_count(input int unsigned vl, input vsew_e sew);
    int unsigned bytes;
    bytes = vl << sew;
    return int'((bytes + WORD_BYTES - 1) / WORD_BYTES);
  endfunction

  function automatic logic [3:0] tail_enable(input int unsigned vl, input vsew_e sew);
    int unsigned rem;
    rem = (vl << sew) % WORD_BYTES;
    if (rem == 0) begin
      return BE_FULL;
    end
    return 4'((32'd1 << rem) - 32'd1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Memory and execution unit model
  //////////////////////////////////////////////////////////////////////

  // Read data comes back one cycle after its grant
  always begin
    @(negedge clk_i);
    send_rvalid = data_req_o && data_gnt_i && !data_we_o;
    @(posedge clk_i);
    #2;
    data_rvalid_i = send_rvalid;
    data_rdata_i  = send_rvalid ? rand_bits(32) : 32'h0;
    // Stall about one cycle in four
    data_gnt_i    = stall_en ? (rand_bits(2) != 32'd0) : 1'b1;
    wdata_i       = rdata_a_o + rdata_b_o;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, want);
      err_cnt++;
    end
  endtask

  task automatic check_be(input string name, input logic [3:0] got, input logic [3:0] want);
    if (got !== want) begin
      $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, want);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int want);
    if (got != want) begin
      $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, want);
      err_cnt++;
    end
  endtask

  // One granted request, compared with the expected operation order
  task automatic check_grant();
    int op;
    int word;
    if (grant_cnt >= exp_grants) begin
      $display("ERROR: %0t memory grant beyond the %0d expected", $time, exp_grants);
      err_cnt++;
    end else begin
      op   = exp_ops[grant_cnt % nops];
      word = grant_cnt / nops;
      check_count("data_we_o", int'(data_we_o), int'(op == OP_RD));
      check_count("agu_get_rs1_o", int'(agu_get_rs1_o), int'(op == OP_RS1));
      check_count("agu_get_rs2_o", int'(agu_get_rs2_o), int'(op == OP_RS2));
      check_count("agu_get_rd_o", int'(agu_get_rd_o), int'(op == OP_RD));
      check_count("agu_incr_o", int'(agu_incr_o), 1);
      if (op == OP_RD) begin
        check_be("data_be_o", data_be_o, (word == exp_words - 1) ? exp_tail : BE_FULL);
        check_word("data_wdata_o", data_wdata_o, last_rs1 + last_rs2);
      end else begin
        check_be("data_be_o", data_be_o, BE_FULL);
        read_is_rs1 = (op == OP_RS1);
        reads_out++;
      end
    end
    grant_cnt++;
  endtask

  // Sample mid-cycle once DUT outputs have settled
  task automatic sample_cycle();
    @(negedge clk_i);
    #1;
    if (rst_ni) begin
      if (agu_incr_o) incr_cnt++;
      if (agu_load_o) load_cnt++;
      // Return data is taken before a grant in the same cycle
      if (data_rvalid_i) begin
        if (read_is_rs1) begin
          last_rs1 = data_rdata_i;
        end else begin
          last_rs2 = data_rdata_i;
        end
        reads_back++;
      end
      if (data_req_o && !active) begin
        $display("ERROR: %0t memory request while no instruction is running", $time);
        err_cnt++;
      end
      if (data_req_o && data_gnt_i) check_grant();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input int pass, input int idx);
    int         errs_before;
    int         waited;
    logic [3:0] sel;
    errs_before = err_cnt;
    sel         = TBL_SEL[idx];
    nops        = 0;
    if (sel[SEL_RS1]) begin
      exp_ops[nops] = OP_RS1;
      nops++;
    end
    if (sel[SEL_RS2]) begin
      exp_ops[nops] = OP_RS2;
      nops++;
    end
    if (sel[SEL_RD]) begin
      exp_ops[nops] = OP_RD;
      nops++;
    end
    exp_words  = word_count(TBL_VL[idx], TBL_SEW[idx]);
    exp_tail   = tail_enable(TBL_VL[idx], TBL_SEW[idx]);
    exp_grants = exp_words * nops;
    grant_cnt  = 0;
    incr_cnt   = 0;
    load_cnt   = 0;
    reads_out  = 0;
    reads_back = 0;

    @(posedge clk_i);
    #2;
    active          = 1'b1;
    req_i           = 1'b1;
    sel_operation_i = sel;
    vl_i            = TBL_VL[idx];
    sew_i           = TBL_SEW[idx];
    waited          = 0;
    sample_cycle();
    while (!ack_o && waited < 20 * exp_words + 20) begin
      sample_cycle();
      waited++;
    end

    if (!ack_o) begin
      $display("ERROR: %0t ack_o did not rise within %0d cycles", $time, waited);
      err_cnt++;
    end else begin
      // Nothing may be left in flight at the acknowledge
      check_count("granted requests at ack_o", grant_cnt, exp_grants);
      check_count("reads outstanding at ack_o", reads_out - reads_back, 0);
      // Operands already hold the last returned data
      check_word("rdata_a_o", rdata_a_o, last_rs1);
      check_word("rdata_b_o", rdata_b_o, last_rs2);
      sample_cycle();
      sample_cycle();
      check_count("ack_o", int'(ack_o), 1);
    end

    // Close the handshake
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    sample_cycle();
    check_count("ack_o", int'(ack_o), 1);
    sample_cycle();
    check_count("ack_o", int'(ack_o), 0);
    active = 1'b0;

    check_count("agu_incr_o pulses", incr_cnt, exp_grants);
    check_count("agu_load_o pulses", load_cnt, 1);

    if (err_cnt == errs_before) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("Test %0d.%0d sel=%b vl=%0d sew=%0d words=%0d grants=%0d: %s",
             pass, idx, sel, TBL_VL[idx], 32'd8 << TBL_SEW[idx], exp_words, grant_cnt,
             (err_cnt == errs_before) ? "ok" : "errors");
  endtask

  initial begin
    int pass;
    int idx;
    rst_ni          = 1'b0;
    req_i           = 1'b0;
    sel_operation_i = '0;
    vl_i            = '0;
    sew_i           = SEW_8;
    stall_en        = 1'b0;
    active          = 1'b0;
    err_cnt         = 0;
    tests_ok        = 0;
    tests_bad       = 0;
    last_rs1        = '0;
    last_rs2        = '0;
    read_is_rs1     = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Quiet outputs out of reset
    sample_cycle();
    check_count("ack_o", int'(ack_o), 0);
    check_count("data_req_o", int'(data_req_o), 0);
    check_count("data_we_o", int'(data_we_o), 0);
    check_count("agu_load_o", int'(agu_load_o), 0);
    check_count("agu_get_rs1_o", int'(agu_get_rs1_o), 0);
    check_count("agu_get_rs2_o", int'(agu_get_rs2_o), 0);
    check_count("agu_get_rd_o", int'(agu_get_rd_o), 0);
    check_count("agu_incr_o", int'(agu_incr_o), 0);

    // Second pass adds random grant stalls
    for (pass = 0; pass < NUM_PASSES; pass++) begin
      stall_en = (pass == 1);
      for (idx = 0; idx < NUM_TESTS; idx++) begin
        run_test(pass, idx);
      end
    end

    $display("Summary: %0d tests, %0d clean, %0d with errors, %0d failed checks",
             tests_ok + tests_bad, tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Budget of 20 cycles per word and some slack per instruction
  initial begin
    int limit;
    int p;
    int i;
    limit = 60;
    for (p = 0; p < NUM_PASSES; p++) begin
      for (i = 0; i < NUM_TESTS; i++) begin
        limit += 20 * word_count(TBL_VL[i], TBL_SEW[i]) + 30;
      end
    end
    repeat (limit) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles", limit);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/vrf_cfg_pkg.sv
verilog/vrf_seq_pkg.sv
verilog/vrf_length_calc.sv
verilog/vrf_access_fsm.sv
verilog/vrf_operand_regs.sv
verilog/vrf_interface.sv
bench/tb_vrf_interface.sv

// ==== Makefile ====
TOP := tb_vrf_interface

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module vrf_interface -f vlog.f
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
